// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_crc_ahb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+hw
hw/ahb_pkg.sv
hw/crc_pkg.sv
hw/crc_cfg_if.sv
hw/ahb_host_if.sv
hw/crc_config_regs.sv
hw/crc_datapath.sv
hw/crc_ahb.sv
tb/tb_crc_ahb.sv

// ==== hw/ahb_host_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_settings.svh"

module ahb_host_if
(
	input  wire                     HCLK,
	input  wire                     HRESETn,
	input  wire [31:0]              HADDR,
	input  wire ahb_pkg::htrans_e   HTRANS,
	input  wire ahb_pkg::hsize_e    HSIZE,
	input  wire                     HWRITE,
	input  wire                     HSEL,
	input  wire                     HREADY,
	input  wire [`CRC_DW-1:0]       HWDATA,
	output logic [`CRC_DW-1:0]      HRDATA,
	output logic                    HREADYOUT,
	output ahb_pkg::hresp_e         HRESP,
	crc_cfg_if.host                 bus
);
	import ahb_pkg::*;
	import crc_pkg::*;

	// Address phase registers hold while the data phase stalls
	crc_reg_e   reg_pp;
	hsize_e     size_pp;
	htrans_e    trans_pp;
	logic       write_pp;
	logic       sel_pp;

	// CR fields
	poly_size_e cr_poly_size;
	rev_in_e    cr_rev_in;
	logic       cr_rev_out;

	logic               sample_bus;
	logic               xfer_wr;
	logic               xfer_rd;
	logic               dr_wr;
	logic               dr_rd;
	logic               init_wr;
	logic               cr_wr;
	logic [`CRC_DW-1:0] cr_rd;

	//////////////////////////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////////////////////////

	// New address phase only when the current data phase completes
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			sel_pp   <= 1'b0;
			write_pp <= 1'b0;
			trans_pp <= IDLE;
		end
		else if (sample_bus)
		begin
			sel_pp   <= HSEL;
			write_pp <= HWRITE;
			trans_pp <= HTRANS;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			reg_pp  <= crc_reg_e'(HADDR[`CRC_ADDR_HI:`CRC_ADDR_LO]);
			size_pp <= HSIZE;
		end
	end

	// SEQ and BUSY beats fall through as idle
	assign xfer_wr = sel_pp && write_pp && (trans_pp == NONSEQ);
	assign xfer_rd = sel_pp && !write_pp && (trans_pp == NONSEQ);

	assign dr_wr   = xfer_wr && (reg_pp == DR);
	assign dr_rd   = xfer_rd && (reg_pp == DR);
	assign init_wr = xfer_wr && (reg_pp == INIT);
	assign cr_wr   = xfer_wr && (reg_pp == CR);

	//////////////////////////////////////////////////////////////////////
	// Wait states and strobes
	//////////////////////////////////////////////////////////////////////

	// Stall on a busy engine, a DR read before the result, or INIT under a chain reset
	assign HREADYOUT = !((dr_wr && bus.buffer_full) ||
		(dr_rd && bus.read_wait) ||
		(init_wr && bus.reset_pending));

	// No error responses
	assign HRESP = OKAY;

	// Held writes strobe only in the completing cycle
	assign bus.buffer_write_en = dr_wr && !bus.buffer_full;
	assign bus.init_en         = init_wr && !bus.reset_pending;
	assign bus.idr_en          = xfer_wr && (reg_pp == IDR);
	assign bus.poly_en         = xfer_wr && (reg_pp == POL);
	assign bus.reset_chain     = cr_wr && HWDATA[0];

	// Write data is sampled straight from the data phase
	assign bus.wdata     = HWDATA;
	assign bus.bus_size  = size_pp;
	assign bus.poly_size = cr_poly_size;
	assign bus.rev_in    = cr_rev_in;
	assign bus.rev_out   = cr_rev_out;

	// Bit 0 of CR is a command and is not stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			cr_poly_size <= P32;
			cr_rev_in    <= REV_NONE;
			cr_rev_out   <= 1'b0;
		end
		else if (cr_wr)
		begin
			cr_poly_size <= poly_size_e'(HWDATA[4:3]);
			cr_rev_in    <= rev_in_e'(HWDATA[6:5]);
			cr_rev_out   <= HWDATA[7];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read data merge
	//////////////////////////////////////////////////////////////////////

	// CR fields read back in place
	assign cr_rd = {{(`CRC_DW-8){1'b0}}, cr_rev_out, cr_rev_in, cr_poly_size, 3'b000};

	always_comb
	begin
		case (reg_pp)
			DR:      HRDATA = bus.crc_out;
			IDR:     HRDATA = {{(`CRC_DW-8){1'b0}}, bus.idr_out};
			CR:      HRDATA = cr_rd;
			INIT:    HRDATA = bus.init_out;
			POL:     HRDATA = bus.poly_out;
			default: HRDATA = '0;
		endcase
	end

	// A strobe after a one-cycle data phase traces back to a selected NONSEQ write on the bus
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		((bus.init_en || bus.idr_en || bus.poly_en || bus.buffer_write_en ||
		bus.reset_chain) && $past(sample_bus))
		|-> $past(HSEL && HWRITE && (HTRANS == NONSEQ)));

	// A DR read never completes while a word folds or a chain reset waits
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_rd && HREADYOUT) |-> !(bus.buffer_full || bus.reset_pending));

endmodule

`default_nettype wire

// ==== hw/ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

	//////////////////////////////////////////////////////////////////////
	// AHB-Lite bus encodings
	//////////////////////////////////////////////////////////////////////

	// HTRANS, only NONSEQ starts a transfer in this peripheral
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// HRESP
	typedef enum logic
	{
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// HSIZE up to one 32-bit word
	typedef enum logic [2:0]
	{
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_e;

endpackage

`default_nettype wire

// ==== hw/crc_ahb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_settings.svh"

module crc_ahb
(
	input  wire                   HCLK,
	input  wire                   HRESETn,
	input  wire [31:0]            HADDR,
	input  wire ahb_pkg::htrans_e HTRANS,
	input  wire ahb_pkg::hsize_e  HSIZE,
	input  wire                   HWRITE,
	input  wire                   HSEL,
	input  wire                   HREADY,
	input  wire [`CRC_DW-1:0]     HWDATA,
	output wire [`CRC_DW-1:0]     HRDATA,
	output wire                   HREADYOUT,
	output wire ahb_pkg::hresp_e  HRESP
);

	// Shared config and status bundle
	crc_cfg_if bus ();

	// AHB slave side, decode and CR
	ahb_host_if u_host
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HSEL      (HSEL),
		.HREADY    (HREADY),
		.HWDATA    (HWDATA),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP),
		.bus       (bus)
	);

	// INIT, POL and IDR
	crc_config_regs u_cfg
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.bus     (bus)
	);

	// Buffer and CRC engine
	crc_datapath u_dp
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.bus     (bus)
	);

endmodule

`default_nettype wire

// ==== hw/crc_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_settings.svh"

interface crc_cfg_if;
	import ahb_pkg::*;
	import crc_pkg::*;

	// Host to the config registers and the datapath
	logic [`CRC_DW-1:0] wdata;
	hsize_e             bus_size;
	poly_size_e         poly_size;
	rev_in_e            rev_in;
	logic               rev_out;
	// One-cycle write strobes
	logic               init_en;
	logic               idr_en;
	logic               poly_en;
	logic               buffer_write_en;
	logic               reset_chain;

	// Datapath status and result
	logic               buffer_full;
	logic               read_wait;
	logic               reset_pending;
	logic [`CRC_DW-1:0] crc_out;

	// Config register contents
	logic [`CRC_DW-1:0] init_out;
	logic [`CRC_DW-1:0] poly_out;
	logic [7:0]         idr_out;

	modport host
	(
		output wdata, bus_size, poly_size, rev_in, rev_out,
		output init_en, idr_en, poly_en, buffer_write_en, reset_chain,
		input  buffer_full, read_wait, reset_pending, crc_out,
		input  init_out, poly_out, idr_out
	);

	modport cfg
	(
		input  wdata, init_en, idr_en, poly_en,
		output init_out, poly_out, idr_out
	);

	modport dp
	(
		input  wdata, bus_size, poly_size, rev_in, rev_out,
		input  buffer_write_en, reset_chain, init_out, poly_out,
		output buffer_full, read_wait, reset_pending, crc_out
	);

endinterface

`default_nettype wire

// ==== hw/crc_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_settings.svh"

module crc_config_regs
(
	input wire     HCLK,
	input wire     HRESETn,
	crc_cfg_if.cfg bus
);

	logic [`CRC_DW-1:0] init_q;
	logic [`CRC_DW-1:0] poly_q;
	logic [7:0]         idr_q;

	// INIT, seed for every chain reset
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			init_q <= `CRC_INIT_RST;
		else if (bus.init_en)
			init_q <= bus.wdata;
	end

	// POL, normal form, top bit implied by the width
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			poly_q <= `CRC_POLY_RST;
		else if (bus.poly_en)
			poly_q <= bus.wdata;
	end

	// IDR, scratch byte
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			idr_q <= `CRC_IDR_RST;
		else if (bus.idr_en)
			idr_q <= bus.wdata[7:0];
	end

	assign bus.init_out = init_q;
	assign bus.poly_out = poly_q;
	assign bus.idr_out  = idr_q;

	// One data phase targets one register
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$onehot0({bus.init_en, bus.idr_en, bus.poly_en}));

endmodule

`default_nettype wire

// ==== hw/crc_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_settings.svh"

module crc_datapath
(
	input wire    HCLK,
	input wire    HRESETn,
	crc_cfg_if.dp bus
);
	import ahb_pkg::*;
	import crc_pkg::*;

	eng_state_e         state;
	logic [`CRC_DW-1:0] buf_q;
	logic [1:0]         bytes_left;
	logic [`CRC_DW-1:0] crc_q;
	logic               reset_pend_q;
	logic               chain_go;
	logic [`CRC_DW-1:0] width_mask;
	logic [4:0]         out_shift;
	logic [`CRC_DW-1:0] crc_masked;

	// Mirror bits inside aligned spans of 1, 8, 16 or 32 bits
	function automatic logic [`CRC_DW-1:0] bit_reverse(input logic [`CRC_DW-1:0] w,
		input rev_in_e mode);
		logic [`CRC_DW-1:0] r;
		logic [4:0]         flip;
		case (mode)
			REV_BYTE: flip = 5'd7;
			REV_HALF: flip = 5'd15;
			REV_WORD: flip = 5'd31;
			default:  flip = 5'd0;
		endcase
		for (int i = 0; i < `CRC_DW; i++)
			r[i] = w[5'(i) ^ flip];
		return r;
	endfunction

	// One data byte, MSB first, into a CRC of the width given by mask
	function automatic logic [`CRC_DW-1:0] crc_byte(input logic [`CRC_DW-1:0] crc,
		input logic [7:0] data, input logic [`CRC_DW-1:0] poly,
		input logic [`CRC_DW-1:0] mask);
		logic [`CRC_DW-1:0] c;
		logic [`CRC_DW-1:0] top;
		logic               fb;
		c = crc & mask;
		// Highest bit inside the mask
		top = mask ^ (mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = (|(c & top)) ^ data[i];
			c = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	// Bytes still to fold after the first one
	function automatic logic [1:0] last_byte(input hsize_e size);
		case (size)
			BYTE:    return 2'd0;
			HALF:    return 2'd1;
			default: return 2'd3;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Width selection and result
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (bus.poly_size)
			P16:
			begin
				width_mask = 32'h0000_FFFF;
				out_shift  = 5'd16;
			end
			P8:
			begin
				width_mask = 32'h0000_00FF;
				out_shift  = 5'd24;
			end
			P7:
			begin
				width_mask = 32'h0000_007F;
				out_shift  = 5'd25;
			end
			default:
			begin
				width_mask = 32'hFFFF_FFFF;
				out_shift  = 5'd0;
			end
		endcase
	end

	assign crc_masked = crc_q & width_mask;
	// Output mirror over the active width only
	assign bus.crc_out = bus.rev_out ? (bit_reverse(crc_masked, REV_WORD) >> out_shift)
		: crc_masked;

	//////////////////////////////////////////////////////////////////////
	// Engine and chain reset
	//////////////////////////////////////////////////////////////////////

	// INIT goes in as soon as no word is in flight
	assign chain_go = (bus.reset_chain || reset_pend_q) && (state == ENG_IDLE);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state        <= ENG_IDLE;
			bytes_left   <= 2'd0;
			reset_pend_q <= 1'b0;
			crc_q        <= `CRC_INIT_RST;
		end
		else
		begin
			if (chain_go)
				reset_pend_q <= 1'b0;
			else if (bus.reset_chain)
				reset_pend_q <= 1'b1;
			if (chain_go)
				crc_q <= bus.init_out;
			else if (state == ENG_RUN)
				crc_q <= crc_byte(crc_q, buf_q[7:0], bus.poly_out, width_mask);
			case (state)
				ENG_IDLE:
				begin
					if (bus.buffer_write_en)
					begin
						state      <= ENG_RUN;
						bytes_left <= last_byte(bus.bus_size);
					end
				end
				default:
				begin
					if (bytes_left == 2'd0)
						state <= ENG_IDLE;
					else
						bytes_left <= bytes_left - 2'd1;
				end
			endcase
		end
	end

	// Input word, low byte first out
	always_ff @(posedge HCLK)
	begin
		if (bus.buffer_write_en)
			buf_q <= bit_reverse(bus.wdata, bus.rev_in);
		else if (state == ENG_RUN)
			buf_q <= buf_q >> 8;
	end

	assign bus.buffer_full   = (state == ENG_RUN);
	assign bus.read_wait     = (state == ENG_RUN) || reset_pend_q;
	assign bus.reset_pending = reset_pend_q;

	// Host holds DR writes off while a word is still folding
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		bus.buffer_write_en |-> !bus.buffer_full);

	// At most four bytes per word
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(state == ENG_RUN) [*4] |=> (state == ENG_IDLE));

endmodule

`default_nettype wire

// ==== hw/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

	//////////////////////////////////////////////////////////////////////
	// CRC register map and operating modes
	//////////////////////////////////////////////////////////////////////

	// Word offsets, taken from HADDR[4:2]
	typedef enum logic [2:0]
	{
		DR   = 3'h0,
		IDR  = 3'h1,
		CR   = 3'h2,
		INIT = 3'h4,
		POL  = 3'h5
	} crc_reg_e;

	// CR[4:3]
	typedef enum logic [1:0]
	{
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_e;

	// CR[6:5], span over which input bits are mirrored
	typedef enum logic [1:0]
	{
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_e;

	// Byte-serial engine
	typedef enum logic
	{
		ENG_IDLE = 1'b0,
		ENG_RUN  = 1'b1
	} eng_state_e;

endpackage

`default_nettype wire

// ==== hw/crc_settings.svh ====
`ifndef CRC_SETTINGS_SVH
`define CRC_SETTINGS_SVH

// Width of the AHB data bus and of every CRC register
`define CRC_DW 32

// HADDR bits that pick one of the word registers
`define CRC_ADDR_HI 4
`define CRC_ADDR_LO 2

// Reset values of the configuration registers
`define CRC_INIT_RST 32'hFFFF_FFFF
// Ethernet CRC-32 polynomial, normal form
`define CRC_POLY_RST 32'h04C1_1DB7
`define CRC_IDR_RST  8'h00

`endif

// ==== tb/tb_crc_ahb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "crc_settings.svh"

module tb_crc_ahb;
	import ahb_pkg::*;
	import crc_pkg::*;

	localparam int   CLK_PERIOD = 40;
	localparam int   RST_CYCLES = 4;
	localparam int   N_RAND     = 8;
	localparam logic OP_WR      = 1'b1;
	localparam logic OP_RD      = 1'b0;
	localparam logic FROM_MODEL = 1'b1;
	localparam logic FIXED      = 1'b0;

	// One bus operation and what a read must return
	typedef struct packed
	{
		logic               wr;
		crc_reg_e           rg;
		hsize_e             sz;
		logic [`CRC_DW-1:0] data;
		logic               from_model;
		logic [`CRC_DW-1:0] exp;
	} row_t;

	logic               HCLK;
	logic               HRESETn;
	logic [31:0]        HADDR;
	htrans_e            HTRANS;
	hsize_e             HSIZE;
	logic               HWRITE;
	logic               HSEL;
	logic               HREADY;
	logic [`CRC_DW-1:0] HWDATA;
	wire  [`CRC_DW-1:0] HRDATA;
	wire                HREADYOUT;
	hresp_e             HRESP;

	row_t               rows[$];
	logic               table_built;

	// Reference model state that follows the register writes
	logic [`CRC_DW-1:0] model_crc;
	logic [`CRC_DW-1:0] model_init;
	logic [`CRC_DW-1:0] model_poly;
	poly_size_e         model_size;
	rev_in_e            model_rev_in;
	logic               model_rev_out;

	crc_ahb dut
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HSEL      (HSEL),
		.HREADY    (HREADY),
		.HWDATA    (HWDATA),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #(CLK_PERIOD / 2) HCLK = ~HCLK;

	//////////////////////////////////////////////////////////////////////
	// Bit-serial reference CRC
	//////////////////////////////////////////////////////////////////////

	function automatic int poly_width(input poly_size_e ps);
		case (ps)
			P16:     return 16;
			P8:      return 8;
			P7:      return 7;
			default: return 32;
		endcase
	endfunction

	function automatic logic [`CRC_DW-1:0] width_mask(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	function automatic int bytes_in(input hsize_e sz);
		case (sz)
			BYTE:    return 1;
			HALF:    return 2;
			default: return 4;
		endcase
	endfunction

	// Bits mirrored inside each aligned span of the word
	function automatic logic [`CRC_DW-1:0] mirror_input(input logic [`CRC_DW-1:0] w,
		input rev_in_e mode);
		logic [`CRC_DW-1:0] r;
		int                 span;
		int                 base;
		case (mode)
			REV_BYTE: span = 8;
			REV_HALF: span = 16;
			REV_WORD: span = 32;
			default:  span = 1;
		endcase
		for (int i = 0; i < 32; i++)
		begin
			base = i - (i % span);
			r[i] = w[base + span - 1 - (i - base)];
		end
		return r;
	endfunction

	// Folds the low byte first and each byte MSB first
	function automatic logic [`CRC_DW-1:0] fold_word(input logic [`CRC_DW-1:0] crc,
		input logic [`CRC_DW-1:0] word, input int nbytes);
		logic [`CRC_DW-1:0] din;
		logic [`CRC_DW-1:0] msk;
		logic               fb;
		int                 w;
		w   = poly_width(model_size);
		msk = width_mask(w);
		din = mirror_input(word, model_rev_in);
		crc = crc & msk;
		for (int b = 0; b < nbytes; b++)
		begin
			for (int k = 7; k >= 0; k--)
			begin
				fb  = crc[w - 1] ^ din[8 * b + k];
				crc = (crc << 1) & msk;
				if (fb)
					crc = crc ^ (model_poly & msk);
			end
		end
		return crc;
	endfunction

	// Expected DR read value with optional mirror over the active width
	function automatic logic [`CRC_DW-1:0] expected_dr();
		logic [`CRC_DW-1:0] c;
		logic [`CRC_DW-1:0] r;
		int                 w;
		w = poly_width(model_size);
		c = model_crc & width_mask(w);
		r = c;
		if (model_rev_out)
		begin
			for (int i = 0; i < w; i++)
				r[i] = c[w - 1 - i];
		end
		return r;
	endfunction

	task automatic update_model(input row_t r);
		case (r.rg)
			DR:   model_crc = fold_word(model_crc, r.data, bytes_in(r.sz));
			INIT: model_init = r.data;
			POL:  model_poly = r.data;
			CR:
			begin
				model_size    = poly_size_e'(r.data[4:3]);
				model_rev_in  = rev_in_e'(r.data[6:5]);
				model_rev_out = r.data[7];
				// Chain reset reloads the INIT in effect now
				if (r.data[0])
					model_crc = model_init;
			end
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks and AHB master
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input logic [`CRC_DW-1:0] got, input logic [`CRC_DW-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s, read %08h, expected %08h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_resp(input hresp_e got, input hresp_e exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s, response %s, expected %s", $time, what,
				got.name(), exp.name());
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s, HREADYOUT %b, expected %b", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Single NONSEQ transfer that starts and ends on a falling edge
	task automatic ahb_transfer(input logic wr, input crc_reg_e rg, input hsize_e sz,
		input logic [`CRC_DW-1:0] wd, output logic [`CRC_DW-1:0] rd, output hresp_e rsp);
		HSEL   = 1'b1;
		HTRANS = NONSEQ;
		HADDR  = {27'h0, rg, 2'b00};
		HWRITE = wr;
		HSIZE  = sz;
		@(posedge HCLK);
		@(negedge HCLK);
		// Data phase with an idle bus behind it
		HSEL   = 1'b0;
		HTRANS = IDLE;
		HWDATA = wd;
		// Slave may stretch the data phase
		while (!HREADYOUT)
		begin
			@(posedge HCLK);
			@(negedge HCLK);
		end
		rd  = HRDATA;
		rsp = HRESP;
		@(posedge HCLK);
		@(negedge HCLK);
	endtask

	function automatic row_t make_row(input logic wr, input crc_reg_e rg, input hsize_e sz,
		input logic [`CRC_DW-1:0] data, input logic from_model, input logic [`CRC_DW-1:0] exp);
		row_t row;
		row.wr         = wr;
		row.rg         = rg;
		row.sz         = sz;
		row.data       = data;
		row.from_model = from_model;
		row.exp        = exp;
		return row;
	endfunction

	task automatic add_row(input logic wr, input crc_reg_e rg, input hsize_e sz,
		input logic [`CRC_DW-1:0] data, input logic from_model, input logic [`CRC_DW-1:0] exp);
		rows.push_back(make_row(wr, rg, sz, data, from_model, exp));
	endtask

	task automatic run_row(input string label, input row_t r);
		logic [`CRC_DW-1:0] rdata;
		logic [`CRC_DW-1:0] exp;
		hresp_e             rsp;
		crc_reg_e           rg;
		rg = r.rg;
		ahb_transfer(r.wr, r.rg, r.sz, r.data, rdata, rsp);
		check_resp(rsp, OKAY, {label, " response"});
		if (r.wr)
			update_model(r);
		else
		begin
			exp = r.from_model ? expected_dr() : r.exp;
			check_word(rdata, exp, {label, " read of ", rg.name()});
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		logic [2:0]         mi;
		logic [`CRC_DW-1:0] cr_val;
		// Reset values
		add_row(OP_RD, INIT, WORD, 32'h0, FIXED, `CRC_INIT_RST);
		add_row(OP_RD, POL, WORD, 32'h0, FIXED, `CRC_POLY_RST);
		add_row(OP_RD, IDR, WORD, 32'h0, FIXED, {24'h0, `CRC_IDR_RST});
		add_row(OP_RD, CR, WORD, 32'h0, FIXED, 32'h0000_0000);
		add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		// Read-back where IDR is one byte and CR keeps bits 7:3
		add_row(OP_WR, IDR, WORD, 32'h1234_56A5, FIXED, 32'h0);
		add_row(OP_RD, IDR, WORD, 32'h0, FIXED, 32'h0000_00A5);
		add_row(OP_WR, INIT, WORD, 32'h89AB_CDEF, FIXED, 32'h0);
		add_row(OP_RD, INIT, WORD, 32'h0, FIXED, 32'h89AB_CDEF);
		add_row(OP_WR, POL, WORD, 32'h1357_9BDF, FIXED, 32'h0);
		add_row(OP_RD, POL, WORD, 32'h0, FIXED, 32'h1357_9BDF);
		add_row(OP_WR, CR, WORD, 32'hFFFF_FFFF, FIXED, 32'h0);
		add_row(OP_RD, CR, WORD, 32'h0, FIXED, 32'h0000_00F8);
		add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		// CRC-32/MPEG-2 of the ASCII digits 1 to 9
		add_row(OP_WR, POL, WORD, 32'h04C1_1DB7, FIXED, 32'h0);
		add_row(OP_WR, INIT, WORD, 32'hFFFF_FFFF, FIXED, 32'h0);
		add_row(OP_WR, CR, WORD, 32'h0000_0001, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h3433_3231, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h3837_3635, FIXED, 32'h0);
		add_row(OP_WR, DR, BYTE, 32'hA5A5_A539, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FIXED, 32'h0376_E6E7);
		// Read right behind a word write stalls on the engine
		add_row(OP_WR, CR, WORD, 32'h0000_0001, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'hDEAD_BEEF, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h0123_4567, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'hCAFE_F00D, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		// Chain reset while busy and INIT held on the pending reset
		add_row(OP_WR, CR, WORD, 32'h0000_0001, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h1122_3344, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h5566_7788, FIXED, 32'h0);
		add_row(OP_WR, CR, WORD, 32'h0000_0001, FIXED, 32'h0);
		add_row(OP_WR, INIT, WORD, 32'h0BAD_F00D, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h99AA_BBCC, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		add_row(OP_RD, INIT, WORD, 32'h0, FIXED, 32'h0BAD_F00D);
		add_row(OP_WR, CR, WORD, 32'h0000_0001, FIXED, 32'h0);
		add_row(OP_WR, DR, WORD, 32'h1234_5678, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		// CRC-16/CCITT-FALSE with junk in the upper lanes
		add_row(OP_WR, INIT, WORD, 32'hFFFF_FFFF, FIXED, 32'h0);
		add_row(OP_WR, POL, WORD, 32'h0000_1021, FIXED, 32'h0);
		add_row(OP_WR, CR, WORD, 32'h0000_0009, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'hDEAD_3231, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'hBEEF_3433, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'h0000_3635, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'hFFFF_3837, FIXED, 32'h0);
		add_row(OP_WR, DR, BYTE, 32'h1234_5639, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FIXED, 32'h0000_29B1);
		// CRC-8/SMBUS
		add_row(OP_WR, INIT, WORD, 32'h0000_0000, FIXED, 32'h0);
		add_row(OP_WR, POL, WORD, 32'h0000_0007, FIXED, 32'h0);
		add_row(OP_WR, CR, WORD, 32'h0000_0011, FIXED, 32'h0);
		add_row(OP_WR, DR, BYTE, 32'h7777_7731, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'h0000_3332, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'hABCD_3534, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'h1111_3736, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'h2222_3938, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FIXED, 32'h0000_00F4);
		// 7-bit width
		add_row(OP_WR, POL, WORD, 32'h0000_0009, FIXED, 32'h0);
		add_row(OP_WR, CR, WORD, 32'h0000_0019, FIXED, 32'h0);
		add_row(OP_WR, DR, BYTE, 32'hFFFF_FFA1, FIXED, 32'h0);
		add_row(OP_WR, DR, HALF, 32'h9999_5C3E, FIXED, 32'h0);
		add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		// Every input reversal with output reversal off and on
		add_row(OP_WR, POL, WORD, 32'h04C1_1DB7, FIXED, 32'h0);
		add_row(OP_WR, INIT, WORD, 32'hFFFF_FFFF, FIXED, 32'h0);
		for (int m = 0; m < 8; m++)
		begin
			mi     = 3'(m);
			cr_val = {24'h0, mi[2], mi[1:0], mi[1:0] + 2'd1, 3'b001};
			add_row(OP_WR, CR, WORD, cr_val, FIXED, 32'h0);
			add_row(OP_WR, DR, WORD, 32'hA1B2_C3D4 ^ {4{5'b0, mi}}, FIXED, 32'h0);
			add_row(OP_WR, DR, HALF, 32'h5E6F_7080 | {29'h0, mi}, FIXED, 32'h0);
			add_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		row_t rnd;
		void'($urandom(57));
		HCLK          = 1'b0;
		HRESETn       = 1'b0;
		HADDR         = 32'h0;
		HTRANS        = IDLE;
		HSIZE         = WORD;
		HWRITE        = 1'b0;
		HSEL          = 1'b0;
		// Only slave on the bus so nothing else stalls
		HREADY        = 1'b1;
		HWDATA        = '0;
		table_built   = 1'b0;
		model_crc     = `CRC_INIT_RST;
		model_init    = `CRC_INIT_RST;
		model_poly    = `CRC_POLY_RST;
		model_size    = P32;
		model_rev_in  = REV_NONE;
		model_rev_out = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (RST_CYCLES) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
		check_ready(HREADYOUT, 1'b1, "idle bus after reset");
		for (int i = 0; i < rows.size(); i++)
			run_row($sformatf("row %0d", i), rows[i]);
		// Random modes, sizes and data
		for (int n = 0; n < N_RAND; n++)
		begin
			rnd = make_row(OP_WR, CR, WORD, {24'h0, 8'($urandom)}, FIXED, 32'h0);
			run_row($sformatf("random %0d", n), rnd);
			rnd = make_row(OP_WR, DR, hsize_e'(3'($urandom_range(2, 0))), $urandom, FIXED,
				32'h0);
			run_row($sformatf("random %0d", n), rnd);
			rnd = make_row(OP_RD, DR, WORD, 32'h0, FROM_MODEL, 32'h0);
			run_row($sformatf("random %0d", n), rnd);
		end
		$display("RESULT: PASS");
		$finish;
	end

	// Ten cycles per transfer bounds the worst stall
	initial
	begin
		longint limit;
		wait (table_built);
		limit = longint'(rows.size() + 3 * N_RAND + RST_CYCLES) * 10 * CLK_PERIOD;
		#(limit);
		$display("timeout: DUT stalled");
		$display("RESULT: FAIL");
		$fatal(1);
	end

endmodule

`default_nettype wire
